// ==== logic/rv_regfile_pkg.sv ====
package rv_regfile_pkg;

    // ########################################
    // Widths
    // ########################################

    localparam int unsigned XLEN       = 32;   // RV32 register width
    localparam int unsigned REG_ADDR_W = 5;    // 32 architectural registers

    // ########################################
    // Port structs
    // ########################################

    // Write-back from the retire side, 38 bits
    typedef struct packed {
        logic                  en;    // Single-cycle write strobe
        logic [REG_ADDR_W-1:0] addr;  // Destination rd
        logic [XLEN-1:0]       data;  // Result to store
    } wb_t;

    // Read request, sampled every edge, 11 bits
    typedef struct packed {
        logic                  valid; // Request present this cycle
        logic [REG_ADDR_W-1:0] rs1;   // Source register 1
        logic [REG_ADDR_W-1:0] rs2;   // Source register 2
    } rd_req_t;

    // Execute-stage operands, 75 bits
    typedef struct packed {
        logic                  valid;   // Operands ready for execute
        logic [REG_ADDR_W-1:0] rs1;     // Index kept for later hazard checks
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_val; // Value of rs1 after all bypasses
        logic [XLEN-1:0]       rs2_val; // Value of rs2 after all bypasses
    } operand_t;

    // Total widths, handy for sanity checks
    localparam int unsigned WB_W      = $bits(wb_t);
    localparam int unsigned RD_REQ_W  = $bits(rd_req_t);
    localparam int unsigned OPERAND_W = $bits(operand_t);

endpackage

// ==== logic/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int DATA_W = 32,                // Word width
    parameter int ADDR_W = 5                  // Depth is 2**ADDR_W
) (
    input  logic              i_clk,
    input  logic              i_we,           // Write enable
    input  logic [ADDR_W-1:0] i_waddr,        // Write address
    input  logic [DATA_W-1:0] i_wdata,        // Write data
    input  logic [ADDR_W-1:0] i_raddr,        // Read address
    output logic [DATA_W-1:0] o_rdata         // Registered read data
);

    localparam int DEPTH = 1 << ADDR_W;       // Number of words

    // ########################################
    // Storage
    // ########################################

    logic [DATA_W-1:0] mem [DEPTH];           // Block RAM array
    logic [DATA_W-1:0] rdata_q;               // Output register of the RAM

    // Read-first behavior: same-address collision returns old word
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;          // Synchronous write
        end
        rdata_q <= mem[i_raddr];              // Sees contents before this edge
    end

    assign o_rdata = rdata_q;                 // One-cycle read latency

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int DATA_W = rv_regfile_pkg::XLEN,       // Word width given to both banks
    parameter int ADDR_W = rv_regfile_pkg::REG_ADDR_W  // Index width given to both banks
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  rv_regfile_pkg::wb_t     i_wb,              // Write-back strobe
    input  rv_regfile_pkg::rd_req_t i_rd_req,          // Source indices
    output logic [DATA_W-1:0]       o_rs1_data,        // Valid one cycle after request
    output logic [DATA_W-1:0]       o_rs2_data,
    output rv_regfile_pkg::wb_t     o_wb_eff           // Write as it took effect
);

    import rv_regfile_pkg::*;

    localparam int NPORT = 2;                          // rs1 and rs2

    // ########################################
    // Write gating
    // ########################################

    wb_t wb_gated;                                     // x0 writes dropped here

    always_comb begin
        wb_gated    = i_wb;
        wb_gated.en = i_wb.en && (i_wb.addr != '0);    // x0 is hardwired
    end

    assign o_wb_eff = wb_gated;                        // Same cycle, no delay

    // ########################################
    // Banks, one copy per read port
    // ########################################

    logic [ADDR_W-1:0] rd_addr [NPORT];                // Read index per port
    logic [DATA_W-1:0] ram_q   [NPORT];                // Raw bank output
    logic [DATA_W-1:0] rd_data [NPORT];                // After zero and forward select

    assign rd_addr[0] = i_rd_req.rs1;
    assign rd_addr[1] = i_rd_req.rs2;

    dual_port_ram #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_rs1_bank (
        .i_clk   (i_clk),
        .i_we    (wb_gated.en),                        // Shared write port
        .i_waddr (wb_gated.addr),
        .i_wdata (wb_gated.data),
        .i_raddr (rd_addr[0]),
        .o_rdata (ram_q[0])
    );

    dual_port_ram #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_rs2_bank (
        .i_clk   (i_clk),
        .i_we    (wb_gated.en),                        // Keeps both copies in sync
        .i_waddr (wb_gated.addr),
        .i_wdata (wb_gated.data),
        .i_raddr (rd_addr[1]),
        .o_rdata (ram_q[1])
    );

    // ########################################
    // Read-during-write and x0
    // ########################################

    logic [NPORT-1:0]  fwd_q;                          // Read hit a write on the same edge
    logic [NPORT-1:0]  zero_q;                         // Read of x0
    logic [DATA_W-1:0] wb_data_q;                      // Data written on the last edge

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fwd_q  <= '0;
            zero_q <= '0;
        end else begin
            for (int p = 0; p < NPORT; p++) begin
                fwd_q[p]  <= wb_gated.en && (rd_addr[p] == wb_gated.addr);
                zero_q[p] <= (rd_addr[p] == '0);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        wb_data_q <= wb_gated.data;                    // Lines up with bank output
    end

    // Zero wins, then forwarded data, then the bank
    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            if (zero_q[p]) begin
                rd_data[p] = '0;
            end else if (fwd_q[p]) begin
                rd_data[p] = wb_data_q;                // Bank still holds old word
            end else begin
                rd_data[p] = ram_q[p];
            end
        end
    end

    assign o_rs1_data = rd_data[0];
    assign o_rs2_data = rd_data[1];

endmodule

// ==== logic/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  rv_regfile_pkg::rd_req_t           i_rd_req,   // Request at edge N
    input  logic [rv_regfile_pkg::XLEN-1:0]   i_rs1_data, // Data for request N, cycle N+1
    input  logic [rv_regfile_pkg::XLEN-1:0]   i_rs2_data,
    input  rv_regfile_pkg::wb_t               i_wb_eff,   // Write landing at edge N+1
    output rv_regfile_pkg::operand_t          o_opr       // Execute-stage operands
);

    import rv_regfile_pkg::*;

    // ########################################
    // Request delay
    // ########################################

    logic                  req_valid_q;                   // Request in flight to the regfile
    logic [REG_ADDR_W-1:0] req_rs1_q;
    logic [REG_ADDR_W-1:0] req_rs2_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= i_rd_req.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        req_rs1_q <= i_rd_req.rs1;                        // Indices need no reset
        req_rs2_q <= i_rd_req.rs2;
    end

    // ########################################
    // Latch with write-back bypass
    // ########################################

    logic            hit_rs1;                             // Write lands on rs1 this edge
    logic            hit_rs2;
    logic [XLEN-1:0] rs1_next;
    logic [XLEN-1:0] rs2_next;

    // en is already low for x0, so x0 stays zero
    assign hit_rs1  = i_wb_eff.en && (i_wb_eff.addr == req_rs1_q);
    assign hit_rs2  = i_wb_eff.en && (i_wb_eff.addr == req_rs2_q);
    assign rs1_next = hit_rs1 ? i_wb_eff.data : i_rs1_data;
    assign rs2_next = hit_rs2 ? i_wb_eff.data : i_rs2_data;

    logic                  opr_valid_q;                   // Cleared by reset
    logic [REG_ADDR_W-1:0] opr_rs1_q;
    logic [REG_ADDR_W-1:0] opr_rs2_q;
    logic [XLEN-1:0]       opr_rs1_val_q;
    logic [XLEN-1:0]       opr_rs2_val_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            opr_valid_q <= 1'b0;
        end else begin
            opr_valid_q <= req_valid_q;                   // Two cycles after the request
        end
    end

    always_ff @(posedge i_clk) begin
        opr_rs1_q     <= req_rs1_q;
        opr_rs2_q     <= req_rs2_q;
        opr_rs1_val_q <= rs1_next;
        opr_rs2_val_q <= rs2_next;
    end

    always_comb begin
        o_opr         = '0;
        o_opr.valid   = opr_valid_q;
        o_opr.rs1     = opr_rs1_q;
        o_opr.rs2     = opr_rs2_q;
        o_opr.rs1_val = opr_rs1_val_q;
        o_opr.rs2_val = opr_rs2_val_q;
    end

endmodule

// ==== logic/regfile_top.sv ====
`timescale 1ns/1ps

module regfile_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  rv_regfile_pkg::wb_t      i_wb,      // Write strobe from write-back
    input  rv_regfile_pkg::rd_req_t  i_rd_req,  // Operand request level
    output rv_regfile_pkg::operand_t o_opr      // Operands, two cycles later
);

    import rv_regfile_pkg::*;

    // ########################################
    // Internal nets
    // ########################################

    logic [XLEN-1:0] rs1_data;                  // Register file read port 1
    logic [XLEN-1:0] rs2_data;                  // Register file read port 2
    wb_t             wb_eff;                    // Write after x0 gating

    // ########################################
    // Register file
    // ########################################

    // Bank widths come from the package
    regfile #(
        .DATA_W (XLEN),
        .ADDR_W (REG_ADDR_W)
    ) u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .i_rd_req   (i_rd_req),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_wb_eff   (wb_eff)
    );

    // ########################################
    // Operand stage
    // ########################################

    operand_stage u_operand_stage (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rd_req   (i_rd_req),                 // Delayed inside to match data
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_wb_eff   (wb_eff),                   // Bypass source in the latch cycle
        .o_opr      (o_opr)
    );

endmodule

// ==== tb/regfile_checker.sv ====
`timescale 1ns/1ps

module regfile_checker (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  rv_regfile_pkg::operand_t i_opr,              // DUT operands
    input  rv_regfile_pkg::operand_t i_exp,              // Expected, valid marks a read
    output int                       o_value_errors,
    output int                       o_protocol_errors,
    output int                       o_pending           // Reads still awaiting a result
);

    import rv_regfile_pkg::*;

    // Result shows up two falling edges after the push
    localparam logic [31:0] LATENCY = 32'd2;

    typedef struct packed {
        logic [31:0] stamp;                              // Falling edge of the push
        operand_t    opr;
    } pending_t;

    pending_t    exp_q[$];
    logic [31:0] cycle;                                  // Falling edges since reset

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%08h expected 0x%08h at cycle %0d", name, got, exp, cycle);
            o_value_errors++;
        end
    endtask

    task automatic check_result(input pending_t e);
        compare_word("o_opr.rs1", 32'(i_opr.rs1), 32'(e.opr.rs1));
        compare_word("o_opr.rs2", 32'(i_opr.rs2), 32'(e.opr.rs2));
        compare_word("o_opr.rs1_val", i_opr.rs1_val, e.opr.rs1_val);
        compare_word("o_opr.rs2_val", i_opr.rs2_val, e.opr.rs2_val);
    endtask

    // ########################################
    // Falling edge, outputs are settled here
    // ########################################

    always @(negedge i_clk) begin : track
        pending_t entry;
        if (!i_rst_n) begin
            cycle = '0;
            exp_q.delete();
            o_value_errors    = 0;
            o_protocol_errors = 0;
        end else begin
            cycle = cycle + 32'd1;
            if (i_opr.valid) begin
                if (exp_q.size() == 0) begin
                    $display("Operand valid at cycle %0d with no read outstanding", cycle);
                    o_protocol_errors++;
                end else begin
                    entry = exp_q.pop_front();
                    if (entry.stamp + LATENCY != cycle) begin
                        $display("Operand valid at cycle %0d, oldest read expects cycle %0d",
                                 cycle, entry.stamp + LATENCY);
                        o_protocol_errors++;
                    end else begin
                        check_result(entry);
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].stamp + LATENCY <= cycle) begin
                $display("No operand valid at cycle %0d for the read pushed at cycle %0d",
                         cycle, exp_q[0].stamp);
                o_protocol_errors++;
                entry = exp_q.pop_front();                 // Drop the lost read
            end
            if (i_exp.valid) begin
                entry.stamp = cycle;
                entry.opr   = i_exp;
                exp_q.push_back(entry);
            end
        end
        o_pending = exp_q.size();
    end

endmodule

// ==== tb/regfile_assert.sv ====
`timescale 1ns/1ps

module regfile_assert (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  rv_regfile_pkg::rd_req_t  i_rd_req,          // Request into the operand stage
    input  rv_regfile_pkg::operand_t i_opr              // Operand register output
);

    import rv_regfile_pkg::*;

    a_valid_in_reset : assert property (@(posedge i_clk) !i_rst_n |-> !i_opr.valid)
        else $error("Operand valid is high while reset is asserted");

    // Fixed two-cycle latency, no gaps and no extras
    a_valid_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_opr.valid == $past(i_rd_req.valid, 2))
        else $error("Operand valid does not follow the request valid two cycles later");

    a_rs1_x0_zero : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_opr.valid && i_opr.rs1 == '0) |-> (i_opr.rs1_val == '0))
        else $error("rs1 is x0 but rs1_val is nonzero");

    a_rs2_x0_zero : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_opr.valid && i_opr.rs2 == '0) |-> (i_opr.rs2_val == '0))
        else $error("rs2 is x0 but rs2_val is nonzero");

endmodule

bind operand_stage regfile_assert u_assert (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_rd_req (i_rd_req),
    .i_opr    (o_opr)
);

// ==== tb/tb_regfile_top.sv ====
`timescale 1ns/1ps

module tb_regfile_top;

    import rv_regfile_pkg::*;

    localparam int    CLK_HALF   = 50;                     // 100 ns clock period
    localparam int    RST_CYCLES = 3;
    localparam int    DRIVE_DLY  = 1;                      // Inputs move 1 ns after the edge
    localparam string STIM_FILE  = "tb/regfile_input.txt";

    // One data line, stimulus plus the operands it should produce
    typedef struct packed {
        wb_t             wb;
        rd_req_t         rd;
        logic [XLEN-1:0] exp_rs1;
        logic [XLEN-1:0] exp_rs2;
    } stim_t;

    logic     clk;
    logic     rst_n;
    wb_t      wb;
    rd_req_t  rd_req;
    operand_t opr;
    operand_t exp_opr;                                     // Expected operands, valid marks a read
    int       value_errors;
    int       protocol_errors;
    int       pending;                                     // Reads not yet answered
    stim_t    stim_q[$];                                   // Whole data file
    int       cycle_limit;                                 // Data lines plus margin
    logic     limit_ready;
    int       cycle_count;

    regfile_top u_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb     (wb),
        .i_rd_req (rd_req),
        .o_opr    (opr)
    );

    regfile_checker u_checker (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_opr             (opr),
        .i_exp             (exp_opr),
        .o_value_errors    (value_errors),
        .o_protocol_errors (protocol_errors),
        .o_pending         (pending)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic load_stimulus(output bit ok);
        int              fd;
        int              n;
        logic [8*128-1:0] text;                            // One raw line
        logic [31:0]     f_en, f_addr, f_data, f_vld, f_rs1, f_rs2, f_exp1, f_exp2;
        stim_t           s;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            text = '0;
            n    = $fgets(text, fd);
            // Comment and blank lines do not parse as eight fields
            if (n > 0 && $sscanf(text, "%h %h %h %h %h %h %h %h", f_en, f_addr, f_data,
                                 f_vld, f_rs1, f_rs2, f_exp1, f_exp2) == 8) begin
                s.wb.en   = f_en[0];
                s.wb.addr = f_addr[REG_ADDR_W-1:0];
                s.wb.data = f_data;
                s.rd.valid = f_vld[0];
                s.rd.rs1  = f_rs1[REG_ADDR_W-1:0];
                s.rd.rs2  = f_rs2[REG_ADDR_W-1:0];
                s.exp_rs1 = f_exp1;
                s.exp_rs2 = f_exp2;
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
        ok = (stim_q.size() > 0);
    endtask

    task automatic drive_line(input stim_t s);
        wb              = s.wb;
        rd_req          = s.rd;
        exp_opr         = '0;
        exp_opr.valid   = s.rd.valid;                      // Only reads are checked
        exp_opr.rs1     = s.rd.rs1;
        exp_opr.rs2     = s.rd.rs2;
        exp_opr.rs1_val = s.exp_rs1;
        exp_opr.rs2_val = s.exp_rs2;
    endtask

    initial begin : main
        bit ok;
        rst_n       = 1'b0;
        wb          = '0;
        rd_req      = '0;
        exp_opr     = '0;
        limit_ready = 1'b0;
        cycle_limit = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Stimulus file %s is missing or holds no data lines", STIM_FILE);
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycle_limit = stim_q.size() + 10;
            limit_ready = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            #DRIVE_DLY rst_n = 1'b1;
            foreach (stim_q[i]) begin
                @(posedge clk);
                #DRIVE_DLY;
                drive_line(stim_q[i]);
            end
            @(posedge clk);
            #DRIVE_DLY;
            wb      = '0;                                  // Bus goes idle
            rd_req  = '0;
            exp_opr = '0;
            while (pending != 0) @(posedge clk);           // Drain in-flight reads
            repeat (2) @(posedge clk);                     // Window for stray valids
            $display("Errors: value %0d, protocol %0d, total %0d",
                     value_errors, protocol_errors, value_errors + protocol_errors);
            if (value_errors + protocol_errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (limit_ready === 1'b1 && rst_n === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the stimulus did not complete", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tb/regfile_input.txt ====
# wb_en wb_addr wb_data rd_valid rs1 rs2 exp_rs1_val exp_rs2_val, all hex, one line per cycle
# Expected values are the operands for this line's read, seen two cycles later
1 01 a0000001 1 00 00 00000000 00000000
1 02 a0000002 1 00 01 00000000 a0000001
1 03 a0000003 1 01 02 a0000001 a0000002
1 04 a0000004 1 02 03 a0000002 a0000003
1 05 a0000005 1 03 04 a0000003 a0000004
1 06 a0000006 1 04 05 a0000004 a0000005
1 07 a0000007 1 05 06 a0000005 a0000006
1 08 a0000008 1 06 07 a0000006 a0000007
1 09 a0000009 1 07 08 a0000007 a0000008
1 0a a000000a 1 08 09 a0000008 a0000009
1 0b a000000b 1 09 0a a0000009 a000000a
1 0c a000000c 1 0a 0b a000000a a000000b
1 0d a000000d 1 0b 0c a000000b a000000c
1 0e a000000e 1 0c 0d a000000c a000000d
1 0f a000000f 1 0d 0e a000000d a000000e
1 10 a0000010 1 0e 0f a000000e a000000f
1 11 a0000011 1 0f 10 a000000f a0000010
1 12 a0000012 1 10 11 a0000010 a0000011
1 13 a0000013 1 11 12 a0000011 a0000012
1 14 a0000014 1 12 13 a0000012 a0000013
1 15 a0000015 1 13 14 a0000013 a0000014
1 16 a0000016 1 14 15 a0000014 a0000015
1 17 a0000017 1 15 16 a0000015 a0000016
1 18 a0000018 1 16 17 a0000016 a0000017
1 19 a0000019 1 17 18 a0000017 a0000018
1 1a a000001a 1 18 19 a0000018 a0000019
1 1b a000001b 1 19 1a a0000019 a000001a
1 1c a000001c 1 1a 1b a000001a a000001b
1 1d a000001d 1 1b 1c a000001b a000001c
1 1e a000001e 1 1c 1d a000001c a000001d
1 1f a000001f 1 1d 1e a000001d a000001e
1 05 55550005 1 05 06 55550005 a0000006
1 07 77770007 1 07 05 77770007 55550005
0 00 00000000 1 08 09 88880008 a0000009
1 08 88880008 1 0a 08 a000000a 88880008
1 0c c0000001 1 0c 0b c0000002 a000000b
1 0c c0000002 1 0b 0c a000000b c0000003
1 0c c0000003 1 0c 0c c0000004 c0000004
1 0c c0000004 1 0c 00 c0000004 00000000
1 00 deadbeef 1 00 00 00000000 00000000
1 00 12345678 1 00 03 00000000 a0000003
0 00 00000000 1 00 00 00000000 00000000
1 00 ffffffff 1 01 00 a0000001 00000000
1 14 20202020 1 0d 0e a000000d a000000e
1 15 21212121 1 0f 0f a000000f a000000f
1 16 22222222 1 14 1f 20202020 a000001f
1 17 23232323 1 15 16 21212121 22222222
0 00 00000000 1 17 02 23232323 a0000002
1 1e 30303030 0 00 00 00000000 00000000
0 00 00000000 1 1e 1d 30303030 a000001d

// ==== flist.f ====
logic/rv_regfile_pkg.sv
logic/dual_port_ram.sv
logic/regfile.sv
logic/operand_stage.sv
logic/regfile_top.sv
tb/regfile_checker.sv
tb/regfile_assert.sv
tb/tb_regfile_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_regfile_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
